/* include/sau_params.svh */
`ifndef SAU_PARAMS_SVH
`define SAU_PARAMS_SVH

// Data word width
`define SAU_WID 64

// Shift and rotate amount width
`define SAU_SHW 6

// Bit count result, enough to hold 0 to 64
`define SAU_CNTW 7

`define SAU_DEAD16 16'hDEAD

`endif

/* hdl/sauPkg.sv */
package sauPkg;

`include "sau_params.svh"

	// ==============================
	// Data widths
	// ==============================
	typedef logic [`SAU_WID-1:0] word_t;
	typedef logic [`SAU_SHW-1:0] shamt_t;
	typedef logic [`SAU_CNTW-1:0] count_t;
	typedef logic [7:0] privLevel_t;
	typedef logic [3:0] chkMode_t;

	// ==============================
	// Instruction fields
	// ==============================
	typedef enum logic [3:0] {OP_R3, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SUBFI,
		OP_CHK} opcode_t;	// Codes 7 to 15 are unknown

	typedef enum logic [4:0] {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_ASL, FN_LSR,
		FN_ASR, FN_ROL, FN_ROR, FN_MOVE, FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU,
		FN_SLEU, FN_CNTLZ, FN_CNTLO, FN_CNTTZ, FN_CNTPOP} func_t;

	typedef enum logic [2:0] {CB_AND = 3'd0, CB_OR = 3'd1, CB_XOR = 3'd2,
		CB_ADD = 3'd3} combine_t;	// 4 to 7 invalid

	// ==============================
	// Unit selections
	// ==============================
	typedef enum logic [3:0] {AO_ADD, AO_SUB, AO_AND, AO_OR, AO_XOR, AO_MOVE, AO_ASL,
		AO_LSR, AO_ASR, AO_ROL, AO_ROR, AO_SUBF} arithOp_t;

	typedef enum logic [2:0] {RS_ARITH, RS_SET, RS_COUNT, RS_ZERO, RS_DEAD} resultSel_t;

	typedef enum logic [2:0] {SO_EQ, SO_NE, SO_LT, SO_LE, SO_LTU, SO_LEU} setOp_t;

	typedef enum logic [1:0] {CO_LZ, CO_LO, CO_TZ, CO_POP} countOp_t;

	typedef enum logic [1:0] {CAUSE_NONE, CAUSE_CHK, CAUSE_UNIMP} cause_t;

endpackage

/* hdl/sauIfs.sv */
`timescale 1ns/1ps

// Operands shared by all datapath units
interface sauOperandIf;
	import sauPkg::*;

	word_t a;
	word_t b;
	word_t c;
	word_t imm;

	modport src (output a, b, c, imm);
	modport sink (input a, b, c, imm);
endinterface

// Decoded control, one set per cycle
interface sauCtrlIf;
	import sauPkg::*;

	arithOp_t arithOp;
	combine_t combine;
	logic combineEn;	// Merge primary value with c
	logic useImm;		// Immediate replaces b
	setOp_t setOp;
	countOp_t countOp;
	logic chkEn;
	resultSel_t resultSel;

	modport ctrl (output arithOp, combine, combineEn, useImm, setOp, countOp, chkEn,
		resultSel);
	modport unit (input arithOp, combine, combineEn, useImm, setOp, countOp, chkEn,
		resultSel);
endinterface

/* hdl/sauDecode.sv */
`timescale 1ns/1ps

module sauDecode
(
	input sauPkg::opcode_t opcode,
	input sauPkg::func_t func,
	input sauPkg::combine_t op3,
	sauCtrlIf.ctrl ctrl
);
	import sauPkg::*;

	logic combFn;

	// ASR and MOVE are left out on purpose, they ignore op3
	assign combFn = (opcode == OP_R3) && (func inside {FN_ADD, FN_SUB, FN_AND, FN_OR,
		FN_XOR, FN_ASL, FN_LSR, FN_ROL, FN_ROR});

	assign ctrl.combine = op3;
	assign ctrl.combineEn = combFn;
	assign ctrl.useImm = opcode inside {OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SUBFI};
	assign ctrl.chkEn = (opcode == OP_CHK);

	// ==============================
	// Primary arithmetic operation
	// ==============================
	always_comb
	begin
		ctrl.arithOp = AO_ADD;
		case (opcode)
		OP_R3:
			case (func)
			FN_SUB: ctrl.arithOp = AO_SUB;
			FN_AND: ctrl.arithOp = AO_AND;
			FN_OR: ctrl.arithOp = AO_OR;
			FN_XOR: ctrl.arithOp = AO_XOR;
			FN_ASL: ctrl.arithOp = AO_ASL;
			FN_LSR: ctrl.arithOp = AO_LSR;
			FN_ASR: ctrl.arithOp = AO_ASR;
			FN_ROL: ctrl.arithOp = AO_ROL;
			FN_ROR: ctrl.arithOp = AO_ROR;
			FN_MOVE: ctrl.arithOp = AO_MOVE;
			default: ctrl.arithOp = AO_ADD;
			endcase
		OP_ANDI: ctrl.arithOp = AO_AND;
		OP_ORI: ctrl.arithOp = AO_OR;
		OP_XORI: ctrl.arithOp = AO_XOR;
		OP_SUBFI: ctrl.arithOp = AO_SUBF;	// imm - a
		default: ctrl.arithOp = AO_ADD;
		endcase
	end

	// Comparison and count selects only matter under RS_SET and RS_COUNT
	always_comb
	begin
		ctrl.setOp = SO_EQ;
		ctrl.countOp = CO_LZ;
		case (func)
		FN_SNE: ctrl.setOp = SO_NE;
		FN_SLT: ctrl.setOp = SO_LT;
		FN_SLE: ctrl.setOp = SO_LE;
		FN_SLTU: ctrl.setOp = SO_LTU;
		FN_SLEU: ctrl.setOp = SO_LEU;
		FN_CNTLO: ctrl.countOp = CO_LO;
		FN_CNTTZ: ctrl.countOp = CO_TZ;
		FN_CNTPOP: ctrl.countOp = CO_POP;
		default: ;
		endcase
	end

	// ==============================
	// Result source
	// ==============================
	always_comb
	begin
		case (opcode)
		OP_R3:
			case (func)
			FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_ASL, FN_LSR, FN_ASR, FN_ROL,
			FN_ROR, FN_MOVE:
				ctrl.resultSel = RS_ARITH;
			FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
				ctrl.resultSel = RS_SET;
			FN_CNTLZ, FN_CNTLO, FN_CNTTZ, FN_CNTPOP:
				ctrl.resultSel = RS_COUNT;
			default:
				ctrl.resultSel = RS_ZERO;	// Unknown register function
			endcase
		OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SUBFI:
			ctrl.resultSel = RS_ARITH;
		OP_CHK:
			ctrl.resultSel = RS_ZERO;	// Check only raises a cause
		default:
			ctrl.resultSel = RS_DEAD;
		endcase
		if (combFn && (op3 > CB_ADD))
			ctrl.resultSel = RS_ZERO;	// Invalid combine code
	end

endmodule

/* hdl/sauArith.sv */
`timescale 1ns/1ps

`include "sau_params.svh"

module sauArith
(
	sauOperandIf.sink ops,
	sauCtrlIf.unit ctrl,
	output sauPkg::word_t arithOut
);
	import sauPkg::*;

	word_t opB;
	word_t primary;
	shamt_t sh;
	logic [2*`SAU_WID-1:0] dbl;
	logic [2*`SAU_WID-1:0] rolFull;
	logic [2*`SAU_WID-1:0] rorFull;

	assign opB = ctrl.useImm ? ops.imm : ops.b;
	assign sh = ops.b[`SAU_SHW-1:0];	// Shifts are register form only

	// Rotates shift a doubled copy of a, wrap bits fall into place
	assign dbl = {ops.a, ops.a};
	assign rolFull = dbl << sh;
	assign rorFull = dbl >> sh;

	// ==============================
	// Primary value
	// ==============================
	always_comb
	begin
		case (ctrl.arithOp)
		AO_ADD: primary = ops.a + opB;
		AO_SUB: primary = ops.a - opB;
		AO_AND: primary = ops.a & opB;
		AO_OR: primary = ops.a | opB;
		AO_XOR: primary = ops.a ^ opB;
		AO_MOVE: primary = ops.b;
		AO_ASL: primary = ops.a << sh;
		AO_LSR: primary = ops.a >> sh;	// Zero fill
		AO_ASR: primary = word_t'($signed(ops.a) >>> sh);
		AO_ROL: primary = rolFull[2*`SAU_WID-1:`SAU_WID];
		AO_ROR: primary = rorFull[`SAU_WID-1:0];
		AO_SUBF: primary = ops.imm - ops.a;
		default: primary = '0;
		endcase
	end

	// Combine stage, merges with c
	always_comb
	begin
		arithOut = primary;
		if (ctrl.combineEn)
			case (ctrl.combine)
			CB_AND: arithOut = primary & ops.c;
			CB_OR: arithOut = primary | ops.c;
			CB_XOR: arithOut = primary ^ ops.c;
			CB_ADD: arithOut = (ctrl.arithOp == AO_SUB) ? primary - ops.c : primary + ops.c;
			default: arithOut = primary;	// Decoder zeroes the result
			endcase
	end

endmodule

/* hdl/sauCompare.sv */
`timescale 1ns/1ps

`include "sau_params.svh"

module sauCompare
(
	sauOperandIf.sink ops,
	sauCtrlIf.unit ctrl,
	output sauPkg::word_t setOut
);
	import sauPkg::*;

	logic hit;
	logic ltS;
	logic ltU;
	logic eq;

	assign eq = (ops.a == ops.b);
	assign ltS = ($signed(ops.a) < $signed(ops.b));
	assign ltU = (ops.a < ops.b);

	always_comb
	begin
		case (ctrl.setOp)
		SO_EQ: hit = eq;
		SO_NE: hit = !eq;
		SO_LT: hit = ltS;
		SO_LE: hit = ltS || eq;
		SO_LTU: hit = ltU;
		SO_LEU: hit = ltU || eq;
		default: hit = 1'b0;
		endcase
	end

	// 1 or 0 in the low bit
	assign setOut = {{(`SAU_WID-1){1'b0}}, hit};

endmodule

/* hdl/sauBitCount.sv */
`timescale 1ns/1ps

`include "sau_params.svh"

module sauBitCount
(
	sauOperandIf.sink ops,
	sauCtrlIf.unit ctrl,
	output sauPkg::count_t countOut
);
	import sauPkg::*;

	count_t lz;
	count_t lo;
	count_t tz;
	count_t pop;

	// Zeros above the highest set bit, full width for zero
	function automatic count_t fnLead(input word_t v);
		count_t n;
		n = count_t'(`SAU_WID);
		for (int i = 0; i < `SAU_WID; i++)
			if (v[i])
				n = count_t'(`SAU_WID - 1 - i);	// Highest set bit wins
		return n;
	endfunction

	// ==============================
	// Counts
	// ==============================
	assign lz = fnLead(ops.a);
	assign lo = fnLead(~ops.a);	// Leading ones are leading zeros of ~a

	always_comb
	begin
		tz = count_t'(`SAU_WID);
		pop = '0;
		for (int i = `SAU_WID - 1; i >= 0; i--)
		begin
			if (ops.a[i])
				tz = count_t'(i);	// Lowest set bit wins
			pop = pop + count_t'(ops.a[i]);
		end
	end

	always_comb
	begin
		case (ctrl.countOp)
		CO_LZ: countOut = lz;
		CO_LO: countOut = lo;
		CO_TZ: countOut = tz;
		default: countOut = pop;
		endcase
	end

endmodule

/* hdl/sauCheck.sv */
`timescale 1ns/1ps

module sauCheck
(
	sauOperandIf.sink ops,
	sauCtrlIf.unit ctrl,
	input sauPkg::chkMode_t chkMode,
	input sauPkg::privLevel_t cpl,
	input sauPkg::word_t canary,
	output sauPkg::cause_t cause
);
	import sauPkg::*;

	logic lowOk;
	logic highOk;
	logic inRange;

	// Mode bit 1 makes the lower bound exclusive, bit 0 the upper bound inclusive
	assign lowOk = chkMode[1] ? (ops.a > ops.b) : (ops.a >= ops.b);
	assign highOk = chkMode[0] ? (ops.a <= ops.c) : (ops.a < ops.c);
	assign inRange = lowOk && highOk;

	always_comb
	begin
		cause = CAUSE_NONE;
		if (ctrl.chkEn)
			case (chkMode)
			4'd0, 4'd1, 4'd2, 4'd3:
				cause = inRange ? CAUSE_NONE : CAUSE_CHK;
			4'd4, 4'd5, 4'd6, 4'd7:
				cause = inRange ? CAUSE_CHK : CAUSE_NONE;
			4'd8:
				cause = (ops.a < word_t'(cpl)) ? CAUSE_CHK : CAUSE_NONE;	// Below privilege
			4'd9:
				cause = (ops.a > word_t'(cpl)) ? CAUSE_CHK : CAUSE_NONE;
			4'd10:
				cause = (ops.a != canary) ? CAUSE_CHK : CAUSE_NONE;	// Stack canary
			default:
				cause = CAUSE_UNIMP;
			endcase
	end

endmodule

/* hdl/sauResult.sv */
`timescale 1ns/1ps

`include "sau_params.svh"

module sauResult
(
	input logic clk,
	input logic reset,
	sauCtrlIf.unit ctrl,
	input sauPkg::word_t arithOut,
	input sauPkg::word_t setOut,
	input sauPkg::count_t countOut,
	input sauPkg::cause_t cause,
	output sauPkg::word_t result,
	output sauPkg::cause_t exc
);
	import sauPkg::*;

	word_t sel;

	always_comb
	begin
		case (ctrl.resultSel)
		RS_ARITH: sel = arithOut;
		RS_SET: sel = setOut;
		RS_COUNT: sel = word_t'(countOut);	// Zero extended
		RS_DEAD: sel = {(`SAU_WID/16){`SAU_DEAD16}};
		default: sel = '0;
		endcase
	end

	// ==============================
	// Output registers
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			exc <= CAUSE_NONE;
		end
		else
		begin
			result <= sel;
			exc <= cause;
		end
	end

endmodule

/* hdl/sauTop.sv */
`timescale 1ns/1ps

module sauTop
(
	input logic clk,
	input logic reset,
	input sauPkg::opcode_t opcode,
	input sauPkg::func_t func,
	input sauPkg::combine_t op3,
	input sauPkg::chkMode_t chkMode,
	input sauPkg::word_t a,
	input sauPkg::word_t b,
	input sauPkg::word_t c,
	input sauPkg::word_t imm,
	input sauPkg::privLevel_t cpl,
	input sauPkg::word_t canary,
	output sauPkg::word_t result,
	output sauPkg::cause_t exc
);
	import sauPkg::*;

	word_t arithOut;
	word_t setOut;
	count_t countOut;
	cause_t cause;

	sauOperandIf ops ();
	sauCtrlIf ctrl ();

	// Operand bundle fed straight from the ports
	assign ops.a = a;
	assign ops.b = b;
	assign ops.c = c;
	assign ops.imm = imm;

	// ==============================
	// Decode and datapath
	// ==============================
	sauDecode u_sauDecode (.opcode(opcode), .func(func), .op3(op3), .ctrl(ctrl));

	sauArith u_sauArith (.ops(ops), .ctrl(ctrl), .arithOut(arithOut));

	sauCompare u_sauCompare (.ops(ops), .ctrl(ctrl), .setOut(setOut));

	sauBitCount u_sauBitCount (.ops(ops), .ctrl(ctrl), .countOut(countOut));

	sauCheck u_sauCheck
	(
		.ops(ops),
		.ctrl(ctrl),
		.chkMode(chkMode),
		.cpl(cpl),
		.canary(canary),
		.cause(cause)
	);

	// Only registered stage, one cycle latency
	sauResult u_sauResult
	(
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.arithOut(arithOut),
		.setOut(setOut),
		.countOut(countOut),
		.cause(cause),
		.result(result),
		.exc(exc)
	);

endmodule

/* test/sau_props.sv */
`timescale 1ns/1ps

module sauProps
(
	input logic clk,
	input logic reset,
	input sauPkg::opcode_t opcode,
	input sauPkg::word_t result,
	input sauPkg::cause_t exc
);
	import sauPkg::*;

	int errCount = 0;	// Read by the testbench at the end

	// ==============================
	// Output properties
	// ==============================
	resetClears: assert property (@(posedge clk) reset |=> (result == '0 && exc == CAUSE_NONE))
	else
	begin
		errCount++;
		$error("result or exc not cleared after a reset edge");
	end

	// A check cause needs a check opcode one cycle earlier
	chkFollowsChk: assert property (@(posedge clk) disable iff (reset)
		(exc == CAUSE_CHK) |-> ($past(opcode) == OP_CHK))
	else
	begin
		errCount++;
		$error("exc is CAUSE_CHK without a preceding OP_CHK");
	end

	excKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(exc))
	else
	begin
		errCount++;
		$error("exc holds an unknown value");
	end

endmodule

bind sauTop sauProps u_sauProps (.clk(clk), .reset(reset), .opcode(opcode), .result(result),
	.exc(exc));

/* test/sauTb.sv */
`timescale 1ns/1ps

module sauTb;
	import sauPkg::*;

	localparam int W = $bits(word_t);
	localparam int NUM_RANDOM = 4000;

	logic clk;
	logic reset;
	opcode_t opcode;
	func_t func;
	combine_t op3;
	chkMode_t chkMode;
	word_t a;
	word_t b;
	word_t c;
	word_t imm;
	privLevel_t cpl;
	word_t canary;
	word_t result;
	cause_t exc;
	integer seed;

	sauTop u_sauTop (.clk(clk), .reset(reset), .opcode(opcode), .func(func), .op3(op3),
		.chkMode(chkMode), .a(a), .b(b), .c(c), .imm(imm), .cpl(cpl), .canary(canary),
		.result(result), .exc(exc));

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	// ==============================
	// Reference model
	// ==============================
	function automatic int leadCount(input word_t w, input logic bitVal);
		int n;
		n = 0;
		while (n < W && w[W-1-n] == bitVal)
			n++;
		return n;
	endfunction

	function automatic int trailZeros(input word_t w);
		int n;
		n = 0;
		while (n < W && !w[n])
			n++;
		return n;
	endfunction

	function automatic int popCount(input word_t w);
		int n;
		n = 0;
		for (int i = 0; i < W; i++)
			n += w[i];
		return n;
	endfunction

	// Signed less-than from the sign bits first
	function automatic logic lessSigned(input word_t x, input word_t y);
		return (x[W-1] != y[W-1]) ? x[W-1] : (x < y);
	endfunction

	function automatic void modelOp(output word_t r, output cause_t e);
		word_t p;
		int s;
		int m;
		logic lowIn;
		logic highIn;
		logic hit;
		r = '0;
		e = CAUSE_NONE;
		p = '0;
		s = b[5:0];
		m = chkMode;
		case (opcode)
		OP_R3:
		begin
			case (func)
			FN_ADD: p = a + b;
			FN_SUB: p = a - b;
			FN_AND: p = a & b;
			FN_OR: p = a | b;
			FN_XOR: p = a ^ b;
			FN_ASL: p = a << s;
			FN_LSR: p = a >> s;
			FN_ASR: p = (a >> s) | (a[W-1] ? ~({W{1'b1}} >> s) : '0);	// Sign fill
			FN_ROL: p = (a << s) | (a >> (W - s));
			FN_ROR: p = (a >> s) | (a << (W - s));
			FN_MOVE: p = b;
			default: p = '0;
			endcase
			if (func inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_ASL, FN_LSR,
				FN_ROL, FN_ROR})
			begin
				case (int'(op3))
				0: r = p & c;
				1: r = p | c;
				2: r = p ^ c;
				3: r = (func == FN_SUB) ? p - c : p + c;
				default: r = '0;	// Invalid combine code
				endcase
			end
			else if (func inside {FN_ASR, FN_MOVE})
				r = p;
			else
				case (func)
				FN_SEQ: r = word_t'(a == b);
				FN_SNE: r = word_t'(a != b);
				FN_SLT: r = word_t'(lessSigned(a, b));
				FN_SLE: r = word_t'(lessSigned(a, b) || a == b);
				FN_SLTU: r = word_t'(a < b);
				FN_SLEU: r = word_t'(a <= b);
				FN_CNTLZ: r = word_t'(leadCount(a, 1'b0));
				FN_CNTLO: r = word_t'(leadCount(a, 1'b1));
				FN_CNTTZ: r = word_t'(trailZeros(a));
				FN_CNTPOP: r = word_t'(popCount(a));
				default: r = '0;	// Unknown function
				endcase
		end
		OP_ADDI: r = a + imm;
		OP_ANDI: r = a & imm;
		OP_ORI: r = a | imm;
		OP_XORI: r = a ^ imm;
		OP_SUBFI: r = imm - a;
		OP_CHK:
		begin
			hit = 1'b0;
			if (m < 8)
			begin
				lowIn = (m % 4 < 2) ? (a >= b) : (a > b);
				highIn = (m % 2 == 0) ? (a < c) : (a <= c);
				hit = (m < 4) ? !(lowIn && highIn) : (lowIn && highIn);
			end
			else if (m == 8)
				hit = a < word_t'(cpl);
			else if (m == 9)
				hit = a > word_t'(cpl);
			else if (m == 10)
				hit = a != canary;
			if (m > 10)
				e = CAUSE_UNIMP;
			else if (hit)
				e = CAUSE_CHK;
		end
		default: r = {4{16'hDEAD}};
		endcase
	endfunction

	// ==============================
	// Checks
	// ==============================
	task automatic checkWord(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "Word mismatch");
		end
	endtask

	task automatic checkCause(input string name, input cause_t got, input cause_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "Cause mismatch");
		end
	endtask

	// Inputs set on this falling edge show up in result by the next one
	task automatic runOp();
		word_t expRes;
		cause_t expCause;
		modelOp(expRes, expCause);
		@(negedge clk);
		checkWord("result", result, expRes);
		checkCause("exc", exc, expCause);
	endtask

	task automatic directedOp(input opcode_t o, input func_t f, input int k, input int m,
		input word_t va, input word_t vb, input word_t vc);
		opcode = o;
		func = f;
		op3 = combine_t'(k);
		chkMode = chkMode_t'(m);
		a = va;
		b = vb;
		c = vc;
		imm = 64'h1234;
		cpl = 8'd5;
		canary = 64'd5;
		runOp();
	endtask

	// ==============================
	// Random stimulus
	// ==============================
	function automatic word_t pickWord();
		logic [31:0] r;
		r = $random(seed);
		case (r[2:0])
		3'd0, 3'd1: return word_t'(r[6:3]);	// Small values
		3'd2: return '0;
		3'd3: return '1;
		3'd4: return word_t'(1) << r[12:7];
		3'd5: return ~(word_t'(1) << r[12:7]);
		default: return {$random(seed), $random(seed)};
		endcase
	endfunction

	task automatic randomOp();
		logic [31:0] r;
		r = $random(seed);
		opcode = r[0] ? OP_R3 : opcode_t'(r[4:1]);
		func = func_t'(r[9:5]);
		op3 = combine_t'(r[12:10]);
		chkMode = chkMode_t'(r[16:13]);
		cpl = privLevel_t'(r[20:17]);
		a = pickWord();
		b = r[21] ? a : pickWord();	// Equal pairs
		c = r[22] ? b + word_t'(r[26:23]) : pickWord();
		imm = pickWord();
		canary = r[27] ? a : pickWord();
	endtask

	initial
	begin
		seed = 32'h916d;
		reset = 1'b1;
		opcode = OP_CHK;	// Mode 15 would raise CAUSE_UNIMP without reset
		func = FN_ADD;
		op3 = CB_AND;
		chkMode = '1;
		a = '0;
		b = '0;
		c = '0;
		imm = '0;
		cpl = '0;
		canary = '0;
		@(posedge clk);
		@(negedge clk);
		opcode = opcode_t'(4'hF);	// Unknown opcode would load DEAD without reset
		@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		checkWord("result", result, '0);
		checkCause("exc", exc, CAUSE_NONE);

		for (int m = 0; m < 16; m++)
			for (int v = 2; v <= 9; v++)
				directedOp(OP_CHK, FN_ADD, 0, m, word_t'(v), 64'd3, 64'd8);
		for (int k = 0; k < 4; k++)
		begin
			directedOp(OP_R3, func_t'(int'(FN_CNTLZ) + k), 0, 0, '0, '0, '0);
			directedOp(OP_R3, func_t'(int'(FN_CNTLZ) + k), 0, 0, '1, '0, '0);
			directedOp(OP_R3, func_t'(int'(FN_CNTLZ) + k), 0, 0, 64'd1, '0, '0);
			directedOp(OP_R3, func_t'(int'(FN_CNTLZ) + k), 0, 0, 64'h8000_0000_0000_0000,
				'0, '0);
		end
		for (int k = 0; k < 6; k++)
		begin
			directedOp(OP_R3, func_t'(int'(FN_SEQ) + k), 0, 0, '1, 64'd1, '0);	// -1 vs 1
			directedOp(OP_R3, func_t'(int'(FN_SEQ) + k), 0, 0, 64'd1, '1, '0);
		end
		directedOp(opcode_t'(4'hC), FN_ADD, 0, 0, 64'd7, 64'd9, '0);
		directedOp(OP_R3, func_t'(5'd30), 0, 0, 64'd7, 64'd9, '0);

		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			randomOp();
			runOp();
		end

		if (u_sauTop.u_sauProps.errCount != 0)
		begin
			$display("Some tests failed");
			$fatal(1, "Bound assertions failed");
		end
		else
		begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

/* verilog.f */
+incdir+include
hdl/sauPkg.sv
hdl/sauIfs.sv
hdl/sauDecode.sv
hdl/sauArith.sv
hdl/sauCompare.sv
hdl/sauBitCount.sv
hdl/sauCheck.sv
hdl/sauResult.sv
hdl/sauTop.sv
test/sau_props.sv
test/sauTb.sv

/* Bender.yml */
package:
  name: sau

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/sauPkg.sv
      - hdl/sauIfs.sv
      - hdl/sauDecode.sv
      - hdl/sauArith.sv
      - hdl/sauCompare.sv
      - hdl/sauBitCount.sv
      - hdl/sauCheck.sv
      - hdl/sauResult.sv
      - hdl/sauTop.sv
  - target: test
    files:
      - test/sau_props.sv
      - test/sauTb.sv
